//--- Makefile
# Verilator build, run, lint and clean for the execution unit testbench.
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR   ?= verilator
TOP         ?= exec_unit_tb
FILELIST    ?= filelist.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
FAIL_MSG    ?= Checks failed
PASS_MSG    ?= All checks passed
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS  ?= --lint-only --timing --assert -Wall

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, so a stopped simulation does not end make here
run: build
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
src/cpu_lab_pkg.sv
src/reg_file.sv
src/alu.sv
src/exec_ctrl.sv
src/exec_unit_top.sv
sim/tb_clock_gen.sv
sim/exec_unit_checker.sv
sim/exec_unit_tb.sv

//--- sim/exec_unit_checker.sv
/*
 * Concurrent assertions on the command timing of the execution unit.
 * Attached to every exec_unit_top instance by the bind at the end.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_unit_checker (
   input wire clk,
   input wire rst,
   input wire start,
   input wire busy,
   input wire done
);

   // Number of assertion failures so far
   int fail_count = 0;

   logic accepted;

   assign accepted = start && !busy;

   ////////////////////////////////////////
   // Command timing
   ////////////////////////////////////////

   // Done three cycles after an accepted start, and never without one
   done_latency: assert property (@(posedge clk) disable iff (rst)
      done == $past(accepted, 3))
   else
   begin
      $error("done does not follow an accepted start by three cycles");
      fail_count++;
   end

   done_not_busy: assert property (@(posedge clk) disable iff (rst)
      !(done && busy))
   else
   begin
      $error("done and busy are high in the same cycle");
      fail_count++;
   end

   done_one_cycle: assert property (@(posedge clk) disable iff (rst)
      done |=> !done)
   else
   begin
      $error("done stays high for more than one cycle");
      fail_count++;
   end

   // First cycle out of reset
   reset_release: assert property (@(posedge clk)
      $fell(rst) |-> (!busy && !done))
   else
   begin
      $error("busy or done is high right after reset");
      fail_count++;
   end

endmodule

bind exec_unit_top exec_unit_checker u_checker (
   .clk   (clk),
   .rst   (rst),
   .start (start),
   .busy  (busy),
   .done  (done)
);

`default_nettype wire

//--- sim/exec_unit_tb.sv
/*
 * Testbench for the execution unit. Runs load-immediate, random ALU,
 * ignored-write and start-while-busy commands against a shadow register
 * array and reads each result back through the debug port.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb
   import cpu_lab_pkg::*;
();

   localparam int NUM_RANDOM  = 200;
   // Load-immediate, random, ignored writes, start while busy
   localparam int CMD_COUNT   = 15 + NUM_RANDOM + 17 + 1;
   localparam int CYCLE_LIMIT = CMD_COUNT * 40 + 500;

   logic     clk;
   logic     rst;
   logic     start;
   alu_op_t  op;
   reg_num_t dst;
   reg_num_t src_a;
   reg_num_t src_b;
   data_t    imm;
   reg_num_t dbg_num;
   logic     busy;
   logic     done;
   data_t    dbg_data;
   led_t     led;

   data_t       shadow [REG_COUNT];
   int unsigned cycle_count = 0;

   tb_clock_gen clock_gen (
      .clk (clk),
      .rst (rst)
   );

   exec_unit_top UUT (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .op       (op),
      .dst      (dst),
      .src_a    (src_a),
      .src_b    (src_b),
      .imm      (imm),
      .dbg_num  (dbg_num),
      .busy     (busy),
      .done     (done),
      .dbg_data (dbg_data),
      .led      (led)
   );

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic data_t alu_model(input alu_op_t f_op, input data_t a, input data_t b,
                                       input data_t imm_val);
      data_t r;
      case (f_op)
         OP_ADD:  r = a + b;
         OP_SUB:  r = a - b;
         OP_AND:  r = a & b;
         OP_OR:   r = a | b;
         OP_XOR:  r = a ^ b;
         OP_SLL:  r = a << b[4:0];
         OP_SRL:  r = a >> b[4:0];
         OP_LDI:  r = imm_val;
         default: r = '0;
      endcase
      return r;
   endfunction

   // r0 and numbers 16 to 31 read as zero
   function automatic data_t shadow_value(input reg_num_t num);
      if (num == '0 || num >= REG_COUNT)
      begin
         return '0;
      end
      return shadow[num[3:0]];
   endfunction

   function automatic reg_num_t random_num(input int max_num);
      return reg_num_t'($urandom_range(max_num, 0));
   endfunction

   ////////////////////////////////////////
   // Checks and command tasks
   ////////////////////////////////////////
   task automatic check_value(input string name, input data_t expected, input data_t actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         $display("Checks failed");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   task automatic run_command(input string name, input alu_op_t c_op, input reg_num_t c_dst,
                              input reg_num_t c_a, input reg_num_t c_b, input data_t c_imm);
      data_t expected;
      int    waited;
      expected = alu_model(c_op, shadow_value(c_a), shadow_value(c_b), c_imm);
      @(posedge clk);
      start <= 1'b1;
      op    <= c_op;
      dst   <= c_dst;
      src_a <= c_a;
      src_b <= c_b;
      imm   <= c_imm;
      @(posedge clk);
      start <= 1'b0;
      waited = 0;
      do
      begin
         @(negedge clk);
         waited++;
      end
      while (!done);
      check_value({name, ", done latency"}, 3, waited);
      if (c_dst != '0 && c_dst < REG_COUNT)
      begin
         shadow[c_dst[3:0]] = expected;
      end
      check_value({name, ", led tap"}, data_t'(shadow[LED_REG][LED_W-1:0]), data_t'(led));
   endtask

   // Debug read while idle, one edge for the read register to load
   task automatic read_back(input reg_num_t num, input data_t expected, input string name);
      @(posedge clk);
      dbg_num <= num;
      @(posedge clk);
      @(negedge clk);
      check_value($sformatf("%s, r%0d", name, num), expected, dbg_data);
   endtask

   task automatic read_all(input string name);
      for (int i = 0; i < REG_COUNT; i++)
      begin
         read_back(reg_num_t'(i), shadow_value(reg_num_t'(i)), name);
      end
   endtask

   ////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Timeout: %0d cycles passed and the tests did not finish", cycle_count);
         $display("Checks failed");
         $fatal(1, "Run stopped at the cycle limit");
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   initial
   begin
      int    pulses;
      data_t first_imm;
      data_t second_imm;
      alu_op_t r_op;
      reg_num_t r_dst;

      void'($urandom(32'hd67c));
      start   = 1'b0;
      op      = OP_ADD;
      dst     = '0;
      src_a   = '0;
      src_b   = '0;
      imm     = '0;
      dbg_num = '0;
      for (int i = 0; i < REG_COUNT; i++)
      begin
         shadow[i] = '0;
      end
      wait (rst === 1'b0);

      for (int n = 0; n < 32; n++)
      begin
         read_back(reg_num_t'(n), '0, "reset readback");
      end
      check_value("led after reset", '0, data_t'(led));

      for (int r = 1; r < REG_COUNT; r++)
      begin
         run_command("load immediate", OP_LDI, reg_num_t'(r), random_num(15), random_num(15),
                     $urandom);
         read_back(reg_num_t'(r), shadow_value(reg_num_t'(r)), "load immediate readback");
      end

      for (int k = 0; k < NUM_RANDOM; k++)
      begin
         r_op  = alu_op_t'($urandom_range(7, 0));
         r_dst = random_num(15);
         run_command($sformatf("random command %0d", k), r_op, r_dst, random_num(15),
                     random_num(15), $urandom);
         read_back(r_dst, shadow_value(r_dst), $sformatf("random command %0d readback", k));
      end
      read_all("after random commands");

      // r0 and the aliased numbers take no write
      for (int n = 0; n < 32; n++)
      begin
         if (n == 0 || n >= REG_COUNT)
         begin
            run_command($sformatf("ignored write to %0d", n), alu_op_t'($urandom_range(7, 0)),
                        reg_num_t'(n), random_num(31), random_num(31), $urandom);
         end
      end
      read_all("after ignored writes");
      for (int n = REG_COUNT; n < 32; n++)
      begin
         read_back(reg_num_t'(n), '0, "aliased number readback");
      end

      // Start held high through READ and EXEC
      first_imm  = $urandom;
      second_imm = $urandom;
      @(posedge clk);
      start <= 1'b1;
      op    <= OP_LDI;
      dst   <= 5'd9;
      imm   <= first_imm;
      @(posedge clk);
      dst <= 5'd10;
      imm <= second_imm;
      @(posedge clk);
      @(posedge clk);
      start <= 1'b0;
      pulses = 0;
      repeat (6)
      begin
         @(negedge clk);
         if (done)
         begin
            pulses++;
         end
      end
      check_value("done pulses for one accepted start", 1, pulses);
      shadow[9] = first_imm;
      read_all("after start while busy");

      if (UUT.u_checker.fail_count == 0)
      begin
         $display("All checks passed");
         $finish;
      end
      else
      begin
         $display("Checks failed");
         $fatal(1, "Timing assertions failed during the run");
      end
   end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
/*
 * Testbench clock and reset. 40 ns clock period, reset held high
 * through the first two rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   localparam int HALF_PERIOD = 20;

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   initial
   begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

//--- src/alu.sv
/*
 * Combinational ALU of the execution unit. Operates on the two registered
 * operands, or passes the latched immediate through for load-immediate.
 */
`timescale 1ns/1ps
`default_nettype none

module alu
   import cpu_lab_pkg::*;
(
   input  alu_op_t op,
   input  data_t   a,
   input  data_t   b,
   input  data_t   imm,
   output data_t   result
);

   // Shifts use only the low five bits of b
   logic [4:0] shamt;

   assign shamt = b[4:0];

   ////////////////////////////////////////
   // Operation select
   ////////////////////////////////////////
   always_comb
   begin
      case (op)
         OP_ADD:
         begin
            result = a + b;
         end
         OP_SUB:
         begin
            result = a - b;
         end
         OP_AND:
         begin
            result = a & b;
         end
         OP_OR:
         begin
            result = a | b;
         end
         OP_XOR:
         begin
            result = a ^ b;
         end
         OP_SLL:
         begin
            result = a << shamt;
         end
         OP_SRL:
         begin
            // Logical, zeros shift in from the top
            result = a >> shamt;
         end
         OP_LDI:
         begin
            result = imm;
         end
         default:
         begin
            result = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- src/cpu_lab_pkg.sv
/*
 * Shared widths, word types, ALU opcodes and controller states for the
 * register-transfer execution unit. Modules import it with a wildcard.
 */
`default_nettype none

package cpu_lab_pkg;

   ////////////////////////////////////////
   // Widths and register file geometry
   ////////////////////////////////////////
   localparam int DATA_W    = 32;
   localparam int REG_NUM_W = 5;
   localparam int REG_COUNT = 16;
   localparam int LED_W     = 7;
   localparam int LED_REG   = 6;

   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [REG_NUM_W-1:0] reg_num_t;
   typedef logic [LED_W-1:0]     led_t;

   ////////////////////////////////////////
   // ALU operations
   ////////////////////////////////////////
   typedef logic [2:0] alu_op_t;

   localparam alu_op_t OP_ADD = 3'd0;
   localparam alu_op_t OP_SUB = 3'd1;
   localparam alu_op_t OP_AND = 3'd2;
   localparam alu_op_t OP_OR  = 3'd3;
   localparam alu_op_t OP_XOR = 3'd4;
   // Shift amount is the low five bits of b
   localparam alu_op_t OP_SLL = 3'd5;
   localparam alu_op_t OP_SRL = 3'd6;
   // Immediate goes straight to the result
   localparam alu_op_t OP_LDI = 3'd7;

   ////////////////////////////////////////
   // Controller states
   ////////////////////////////////////////
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_EXEC,
      ST_DONE
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/exec_ctrl.sv
/*
 * Command controller. Accepts a start strobe while not busy, latches the
 * command and steps through read, execute and write-back, then pulses done.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl
   import cpu_lab_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  wire      start,
   input  alu_op_t  op,
   input  reg_num_t dst,
   input  reg_num_t src_a,
   input  reg_num_t src_b,
   input  data_t    imm,
   output logic     busy,
   output logic     done,
   output reg_num_t rnum_a,
   output reg_num_t rnum_b,
   output reg_num_t wnum,
   output logic     we,
   output alu_op_t  op_q,
   output data_t    imm_q
);

   ctrl_state_t state;
   ctrl_state_t state_nxt;

   logic     accept;
   reg_num_t dst_q;
   reg_num_t src_a_q;
   reg_num_t src_b_q;

   // Start counts only while busy is low
   assign accept = start && !busy;

   ////////////////////////////////////////
   // State machine
   ////////////////////////////////////////
   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_IDLE:
         begin
            if (accept)
            begin
               state_nxt = ST_READ;
            end
         end
         ST_READ:
         begin
            state_nxt = ST_EXEC;
         end
         ST_EXEC:
         begin
            state_nxt = ST_DONE;
         end
         ST_DONE:
         begin
            // Back-to-back command may start here
            state_nxt = accept ? ST_READ : ST_IDLE;
         end
         default:
         begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= ST_IDLE;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   ////////////////////////////////////////
   // Command register
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         op_q    <= OP_ADD;
         dst_q   <= '0;
         src_a_q <= '0;
         src_b_q <= '0;
      end
      else if (accept)
      begin
         op_q    <= op;
         dst_q   <= dst;
         src_a_q <= src_a;
         src_b_q <= src_b;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         imm_q <= imm;
      end
   end

   // Outputs decoded from the state and the latched fields
   assign busy   = (state == ST_READ) || (state == ST_EXEC);
   assign done   = (state == ST_DONE);
   assign we     = (state == ST_EXEC);
   assign rnum_a = src_a_q;
   assign rnum_b = src_b_q;
   assign wnum   = dst_q;

endmodule

`default_nettype wire

//--- src/exec_unit_top.sv
/*
 * Top level of the execution unit. Joins the controller, register file and
 * ALU; the debug number reads through the third register file port.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_unit_top
   import cpu_lab_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  wire      start,
   input  alu_op_t  op,
   input  reg_num_t dst,
   input  reg_num_t src_a,
   input  reg_num_t src_b,
   input  data_t    imm,
   input  reg_num_t dbg_num,
   output logic     busy,
   output logic     done,
   output data_t    dbg_data,
   output led_t     led
);

   reg_num_t rnum_a;
   reg_num_t rnum_b;
   reg_num_t wnum;
   logic     we;
   alu_op_t  op_q;
   data_t    imm_q;
   data_t    rdata_a;
   data_t    rdata_b;
   data_t    alu_result;

   ////////////////////////////////////////
   // Controller
   ////////////////////////////////////////
   exec_ctrl u_ctrl (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .op     (op),
      .dst    (dst),
      .src_a  (src_a),
      .src_b  (src_b),
      .imm    (imm),
      .busy   (busy),
      .done   (done),
      .rnum_a (rnum_a),
      .rnum_b (rnum_b),
      .wnum   (wnum),
      .we     (we),
      .op_q   (op_q),
      .imm_q  (imm_q)
   );

   ////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////
   reg_file u_regs (
      .clk     (clk),
      .rst     (rst),
      .rnum_a  (rnum_a),
      .rnum_b  (rnum_b),
      .rnum_c  (dbg_num),
      .wnum    (wnum),
      .wdata   (alu_result),
      .we      (we),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b),
      .rdata_c (dbg_data),
      .led     (led)
   );

   alu u_alu (
      .op     (op_q),
      .a      (rdata_a),
      .b      (rdata_b),
      .imm    (imm_q),
      .result (alu_result)
   );

endmodule

`default_nettype wire

//--- src/reg_file.sv
/*
 * Register file with 16 words, three registered read ports and an LED tap.
 * Register 0 reads as zero, numbers 16 to 31 alias it and ignore writes.
 * Read ports only update in cycles without a write.
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file
   import cpu_lab_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  reg_num_t rnum_a,
   input  reg_num_t rnum_b,
   input  reg_num_t rnum_c,
   input  reg_num_t wnum,
   input  data_t    wdata,
   input  wire      we,
   output data_t    rdata_a,
   output data_t    rdata_b,
   output data_t    rdata_c,
   output led_t     led
);

   data_t regs [REG_COUNT];

   ////////////////////////////////////////
   // Number decode
   ////////////////////////////////////////

   // True for the writable registers 1 to 15
   function automatic logic is_real_reg(input reg_num_t num);
      return (num != '0) && (num < REG_COUNT);
   endfunction

   // Zero and out-of-range numbers read as zero
   function automatic data_t read_word(input reg_num_t num);
      data_t word;
      if (is_real_reg(num))
      begin
         word = regs[num[$clog2(REG_COUNT)-1:0]];
      end
      else
      begin
         word = '0;
      end
      return word;
   endfunction

   ////////////////////////////////////////
   // Storage and read registers
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         for (int i = 0; i < REG_COUNT; i++)
         begin
            regs[i] <= '0;
         end
         rdata_a <= '0;
         rdata_b <= '0;
         rdata_c <= '0;
      end
      else if (we)
      begin
         // Read ports hold while a write lands
         if (is_real_reg(wnum))
         begin
            regs[wnum[$clog2(REG_COUNT)-1:0]] <= wdata;
         end
      end
      else
      begin
         rdata_a <= read_word(rnum_a);
         rdata_b <= read_word(rnum_b);
         rdata_c <= read_word(rnum_c);
      end
   end

   // Raw low bits of r6 for the board LEDs
   assign led = regs[LED_REG][LED_W-1:0];

endmodule

`default_nettype wire
